// ==== verilog.f ====
+incdir+include
hw/rename_pkg.sv
hw/free_list_if.sv
hw/map_table_if.sv
hw/free_list.sv
hw/map_table.sv
hw/rename_ctrl.sv
hw/rename_unit.sv
sim/rename_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rename unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    -f verilog.f --top-module rename_tb -Mdir obj_dir

status=0
output=$(./obj_dir/Vrename_tb 2>&1) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && grep -q "PASS: all tests" <<< "$output"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== sim/rename_tb.sv ====
// testbench for the rename unit
// directed tests against a reference model of map table and free tag stack
// clock, reset, four-phase driver and checker tasks

`timescale 1ns/100ps

`include "rename_defines.svh"

module rename_tb;
    import rename_pkg::*;

    localparam int TIMEOUT = 20;

    logic clk, reset, req, ack, ok;
    rename_op_e op;
    arch_reg_t  rd, rs1, rs2;
    tag_t       free_tag, src1_tag, src2_tag, new_tag, old_tag;

    // reference model
    tag_t model_map [`ARCH_REG_SZ];
    tag_t model_stack [`FREE_SZ];
    int   model_cnt;
    // displaced tags waiting to be retired
    tag_t pool [$];
    tag_t exp_src1, exp_src2, exp_new, exp_old;
    logic exp_ok;
    int   seed;

    rename_unit UUT (
        .clk(clk), .reset(reset), .req(req), .op(op),
        .rd(rd), .rs1(rs1), .rs2(rs2), .free_tag(free_tag),
        .ack(ack), .ok(ok), .src1_tag(src1_tag), .src2_tag(src2_tag),
        .new_tag(new_tag), .old_tag(old_tag)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch in %s: expected %0d, actual %0d", name, expected, actual);
            stop_on_error();
        end
    endtask

    // apply the rename and retire rules, set the expected outputs
    task automatic model_step(input rename_op_e o, input arch_reg_t d,
                              input arch_reg_t s1, input arch_reg_t s2, input tag_t t);
        if (o == OP_RENAME) begin
            // sources are read even when the rename is refused
            exp_src1 = model_map[s1];
            exp_src2 = model_map[s2];
            exp_ok = (model_cnt > 0);
            if (exp_ok) begin
                exp_new = model_stack[model_cnt-1];
                exp_old = model_map[d];
                model_map[d] = exp_new;
                model_cnt--;
                pool.push_back(exp_old);
            end
        end else begin
            exp_ok = (model_cnt < `FREE_SZ);
            if (exp_ok) begin
                model_stack[model_cnt] = t;
                model_cnt++;
            end
        end
    endtask

    // all result outputs against the model
    task automatic check_results(input string name);
        check_value({name, " ok"}, 32'(exp_ok), 32'(ok));
        check_value({name, " src1_tag"}, 32'(exp_src1), 32'(src1_tag));
        check_value({name, " src2_tag"}, 32'(exp_src2), 32'(src2_tag));
        check_value({name, " new_tag"}, 32'(exp_new), 32'(new_tag));
        check_value({name, " old_tag"}, 32'(exp_old), 32'(old_tag));
    endtask

    // one four-phase exchange, entered and left 1 ns after a rising edge
    task automatic do_op(input string name, input rename_op_e o, input arch_reg_t d,
                         input arch_reg_t s1, input arch_reg_t s2, input tag_t t);
        int cycles;
        model_step(o, d, s1, s2, t);
        op = o;
        rd = d;
        rs1 = s1;
        rs2 = s2;
        free_tag = t;
        req = 1'b1;
        cycles = 0;
        while (!ack) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("%s: ack never rose after req was raised", name);
                stop_on_error();
            end
        end
        check_results(name);
        req = 1'b0;
        cycles = 0;
        while (ack) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("%s: ack never fell after req was dropped", name);
                stop_on_error();
            end
        end
    endtask

    // first rename after reset sees the identity map
    task automatic reset_mapping();
        do_op("reset_mapping", OP_RENAME, 0, 3, 7, 0);
        check_value("reset_mapping new_tag top", 15, 32'(new_tag));
    endtask

    // chain on r0, rs1 reads the mapping before the write
    task automatic rename_chain();
        tag_t prev;
        prev = exp_new;
        for (int k = 0; k < 4; k++) begin
            do_op("rename_chain", OP_RENAME, 0, 0, 5, 0);
            check_value("rename_chain src1", 32'(prev), 32'(src1_tag));
            check_value("rename_chain old", 32'(prev), 32'(old_tag));
            check_value("rename_chain lifo", 32'(prev) - 1, 32'(new_tag));
            prev = exp_new;
        end
    endtask

    // retired tag comes straight back
    task automatic retire_reuse();
        tag_t t;
        t = pool.pop_back();
        do_op("retire_reuse retire", OP_RETIRE, 0, 0, 0, t);
        do_op("retire_reuse rename", OP_RENAME, 1, 1, 2, 0);
        check_value("retire_reuse tag", 32'(t), 32'(new_tag));
    endtask

    // drain, refuse twice, refill, refuse once
    task automatic exhaust_and_full();
        tag_t t;
        for (int k = 0; model_cnt > 0; k++) begin
            do_op("exhaust", OP_RENAME, arch_reg_t'(k), arch_reg_t'(k + 1), 0, 0);
        end
        do_op("exhaust refused", OP_RENAME, 5, 5, 6, 0);
        do_op("exhaust map kept", OP_RENAME, 5, 5, 6, 0);
        check_value("exhaust refused ok", 0, 32'(ok));
        while (model_cnt < `FREE_SZ) begin
            t = pool.pop_back();
            do_op("refill", OP_RETIRE, 0, 0, 0, t);
        end
        do_op("full refused", OP_RETIRE, 0, 0, 0, 0);
        check_value("full refused ok", 0, 32'(ok));
    endtask

    // random mix, retire tags from the displaced pool
    task automatic random_mix();
        tag_t t;
        int   r;
        for (int n = 0; n < 200; n++) begin
            r = $random(seed);
            if (pool.size() == 0 || r[0] == 1'b0) begin
                do_op("random rename", OP_RENAME, arch_reg_t'($random(seed)),
                      arch_reg_t'($random(seed)), arch_reg_t'($random(seed)), 0);
            end else begin
                r = ($random(seed) & 32'h7fff_ffff) % pool.size();
                t = pool[r];
                pool.delete(r);
                do_op("random retire", OP_RETIRE, 0, 0, 0, t);
            end
        end
    endtask

    // ack timing fixed by the handshake, results frozen while req held
    task automatic handshake_timing();
        model_step(OP_RENAME, 4, 1, 6, 0);
        op = OP_RENAME;
        rd = 4;
        rs1 = 1;
        rs2 = 6;
        req = 1'b1;
        @(posedge clk);
        #1;
        check_value("handshake ack first cycle", 0, 32'(ack));
        @(posedge clk);
        #1;
        check_value("handshake ack second edge", 1, 32'(ack));
        check_results("handshake");
        repeat (5) begin
            @(posedge clk);
            #1;
            check_value("handshake ack held", 1, 32'(ack));
            check_results("handshake held");
        end
        req = 1'b0;
        @(posedge clk);
        #1;
        check_value("handshake ack fall", 0, 32'(ack));
    endtask

    initial begin
        seed = 94;
        reset = 1'b1;
        req = 1'b0;
        op = OP_RENAME;
        rd = '0;
        rs1 = '0;
        rs2 = '0;
        free_tag = '0;
        // identity map, upper tags on the stack
        for (int i = 0; i < `ARCH_REG_SZ; i++) begin
            model_map[i] = tag_t'(i);
        end
        for (int i = 0; i < `FREE_SZ; i++) begin
            model_stack[i] = tag_t'(`ARCH_REG_SZ + i);
        end
        model_cnt = `FREE_SZ;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        reset_mapping();
        rename_chain();
        retire_reuse();
        exhaust_and_full();
        random_mix();
        handshake_timing();

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== hw/rename_unit.sv ====
// rename stage top level
// control plus free list and map table, joined by two interface bundles

`timescale 1ns/100ps

module rename_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  rename_pkg::rename_op_e op,
    input  rename_pkg::arch_reg_t  rd,
    input  rename_pkg::arch_reg_t  rs1,
    input  rename_pkg::arch_reg_t  rs2,
    input  rename_pkg::tag_t       free_tag,
    output logic                   ack,
    output logic                   ok,
    output rename_pkg::tag_t       src1_tag,
    output rename_pkg::tag_t       src2_tag,
    output rename_pkg::tag_t       new_tag,
    output rename_pkg::tag_t       old_tag
);
    import rename_pkg::*;

    // internal bundles
    free_list_if fl_bus ();
    map_table_if mt_bus ();

    // handshake and sequencing
    rename_ctrl u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .op       (op),
        .rd       (rd),
        .rs1      (rs1),
        .rs2      (rs2),
        .free_tag (free_tag),
        .ack      (ack),
        .ok       (ok),
        .src1_tag (src1_tag),
        .src2_tag (src2_tag),
        .new_tag  (new_tag),
        .old_tag  (old_tag),
        .fl       (fl_bus.initiator),
        .mt       (mt_bus.initiator)
    );

    // stack of free tags
    free_list u_free_list (
        .clk   (clk),
        .reset (reset),
        .fl    (fl_bus.target)
    );

    // arch to phys mapping
    map_table u_map_table (
        .clk   (clk),
        .reset (reset),
        .mt    (mt_bus.target)
    );

endmodule

// ==== hw/rename_ctrl.sv ====
// rename control FSM
// four-phase req/ack toward the requester
// single-cycle pop, push and map write strobes toward the datapath
// result registers held through the ack phase

`timescale 1ns/100ps

module rename_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  rename_pkg::rename_op_e op,
    input  rename_pkg::arch_reg_t  rd,
    input  rename_pkg::arch_reg_t  rs1,
    input  rename_pkg::arch_reg_t  rs2,
    input  rename_pkg::tag_t       free_tag,
    output logic                   ack,
    output logic                   ok,
    output rename_pkg::tag_t       src1_tag,
    output rename_pkg::tag_t       src2_tag,
    output rename_pkg::tag_t       new_tag,
    output rename_pkg::tag_t       old_tag,
    free_list_if.initiator         fl,
    map_table_if.initiator         mt
);
    import rename_pkg::*;

    rename_state_e state;
    logic          in_exec;
    logic          is_rename;
    logic          rename_go;
    logic          retire_go;
    logic          op_ok;

    // opcode decode
    assign is_rename = (op == OP_RENAME);
    assign in_exec   = (state == ST_EXEC);

    // refuse a rename on empty, a retire on full
    assign op_ok     = is_rename ? !fl.empty : !fl.full;
    assign rename_go = in_exec && is_rename && !fl.empty;
    assign retire_go = in_exec && !is_rename && !fl.full;

    // operands held stable by the requester while req is high
    assign mt.rd_idx  = rd;
    assign mt.rs1_idx = rs1;
    assign mt.rs2_idx = rs2;

    // rename pops the top tag into the map
    assign fl.pop    = rename_go;
    assign mt.wr_en  = rename_go;
    assign mt.wr_tag = fl.tag_out;

    // retire hands the tag back
    assign fl.push   = retire_go;
    assign fl.tag_in = free_tag;

    // handshake state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
            ack   <= 1'b0;
            ok    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    // operation lands on this edge
                    state <= ST_ACK;
                    ack   <= 1'b1;
                    ok    <= op_ok;
                end
                ST_ACK: begin
                    // wait for the requester to let go
                    if (!req) begin
                        state <= ST_IDLE;
                        ack   <= 1'b0;
                        ok    <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // result capture, only in exec so values hold during ack
    always_ff @(posedge clk) begin
        // sources captured even for a refused rename
        if (in_exec && is_rename) begin
            src1_tag <= mt.rs1_tag;
            src2_tag <= mt.rs2_tag;
        end
        // new and old tags only when the pop happens
        if (rename_go) begin
            new_tag <= fl.tag_out;
            old_tag <= mt.rd_tag;
        end
    end

endmodule

// ==== hw/map_table.sv ====
// architectural to physical register map
// two source read ports, destination read, one write port

`timescale 1ns/100ps

`include "rename_defines.svh"

module map_table (
    input logic         clk,
    input logic         reset,
    map_table_if.target mt
);
    import rename_pkg::*;

    // one tag per architectural register
    tag_t map_q [`ARCH_REG_SZ];

    // identity mapping at reset
    // written on the edge after wr_en
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REG_SZ; i++) begin
                map_q[i] <= tag_t'(i);
            end
        end else if (mt.wr_en) begin
            map_q[mt.rd_idx] <= mt.wr_tag;
        end
    end

    // source lookups
    // an rs equal to rd sees the old tag in the write cycle
    assign mt.rs1_tag = map_q[mt.rs1_idx];
    assign mt.rs2_tag = map_q[mt.rs2_idx];

    // tag displaced by a rename of rd
    assign mt.rd_tag = map_q[mt.rd_idx];

endmodule

// ==== hw/free_list.sv ====
// LIFO of free physical tags
// preloaded with the tags above the architectural range at reset

`timescale 1ns/100ps

`include "rename_defines.svh"

module free_list #(
    parameter int STACK_SIZE = `FREE_SZ
) (
    input logic         clk,
    input logic         reset,
    free_list_if.target fl
);
    import rename_pkg::*;

    // stack index width, top needs one more bit to count to full
    localparam int IDX_W = $clog2(STACK_SIZE);
    localparam int TOP_W = IDX_W + 1;
    localparam logic [IDX_W:0] TOP_FULL = TOP_W'(STACK_SIZE);

    tag_t           stack [STACK_SIZE];
    // number of valid entries
    logic [IDX_W:0] top;
    // slot of the current top entry
    logic [IDX_W:0] top_m1;

    assign top_m1 = top - 1'b1;

    // stack and pointer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // entry i holds tag ARCH_REG_SZ+i, so the highest tag pops first
            for (int i = 0; i < STACK_SIZE; i++) begin
                stack[i] <= tag_t'(`ARCH_REG_SZ + i);
            end
            top <= TOP_FULL;
        end else if (fl.push && !fl.full) begin
            // write above the current top
            stack[top[IDX_W-1:0]] <= fl.tag_in;
            top <= top + 1'b1;
        end else if (fl.pop && !fl.empty) begin
            // entry stays in place, just drops out of range
            top <= top_m1;
        end
    end

    // status from the pointer
    assign fl.empty = (top == '0);
    assign fl.full  = (top == TOP_FULL);

    // entry just below top
    // meaningless when empty, control checks empty first
    assign fl.tag_out = stack[top_m1[IDX_W-1:0]];

endmodule

// ==== hw/map_table_if.sv ====
// map table bundle
// read indices and tags, destination write strobe and tag

`timescale 1ns/100ps

interface map_table_if;
    import rename_pkg::*;

    // indices driven by control
    arch_reg_t rd_idx;
    arch_reg_t rs1_idx;
    arch_reg_t rs2_idx;

    // write port, entry rd_idx
    logic      wr_en;
    tag_t      wr_tag;

    // combinational reads
    // mapping as of before this cycle's write
    tag_t      rs1_tag;
    tag_t      rs2_tag;
    tag_t      rd_tag;

    // control side
    modport initiator (
        output rd_idx, rs1_idx, rs2_idx, wr_en, wr_tag,
        input  rs1_tag, rs2_tag, rd_tag
    );

    // table side
    modport target (
        input  rd_idx, rs1_idx, rs2_idx, wr_en, wr_tag,
        output rs1_tag, rs2_tag, rd_tag
    );

endinterface

// ==== hw/free_list_if.sv ====
// free list bundle
// push/pop strobes, tag in and out, stack status

`timescale 1ns/100ps

interface free_list_if;
    import rename_pkg::*;

    // strobes from control, never both high
    logic push;
    logic pop;
    // tag returned on a retire
    tag_t tag_in;
    // top of stack, valid while not empty
    tag_t tag_out;
    logic empty;
    logic full;

    // control side
    modport initiator (output push, pop, tag_in, input tag_out, empty, full);

    // stack side
    modport target (input push, pop, tag_in, output tag_out, empty, full);

endinterface

// ==== hw/rename_pkg.sv ====
// shared types for the rename stage
// tag and register index types, opcode and control state enums

package rename_pkg;

    `include "rename_defines.svh"

    // physical register tag
    typedef logic [`TAG_W-1:0] tag_t;

    // architectural register index
    typedef logic [`ARCH_W-1:0] arch_reg_t;

    // request opcode
    typedef enum logic {
        OP_RENAME = 1'b0,
        OP_RETIRE = 1'b1
    } rename_op_e;

    // control states
    // exec is the single cycle where strobes fire
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_EXEC = 2'd1,
        ST_ACK  = 2'd2
    } rename_state_e;

endpackage

// ==== include/rename_defines.svh ====
// register counts and tag widths for the rename stage
// free list capacity follows from physical minus architectural count

`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// architectural register file size
`define ARCH_REG_SZ 8

// physical register file size
`define PHYS_REG_SZ 16

// bits of a physical tag and of an architectural index
`define TAG_W 4
`define ARCH_W 3

// tags not mapped after reset live on the free list
`define FREE_SZ (`PHYS_REG_SZ - `ARCH_REG_SZ)

`endif
